// File: common/pgas_pkg.sv
// Shared widths, command opcodes, decoder states, FX2 FIFO addresses and
// reply words for the PGAS debug demo system
package pgas_pkg;

   localparam int usb_word_w = 16;   // FX2 data bus
   localparam int wb_addr_w  = 32;
   localparam int wb_data_w  = 32;

   // Opcode sits in the top nibble of a command word
   typedef enum logic [3:0] {
      op_read_id   = 4'd1,
      op_sys_ctrl  = 4'd2,
      op_mem_write = 4'd3,
      op_mem_read  = 4'd4
   } dbg_opcode_e;

   // Bit positions inside an op_sys_ctrl word
   localparam int ctrl_halt_bit  = 0;
   localparam int ctrl_reset_bit = 1;
   localparam int ctrl_start_bit = 2;

   typedef enum logic [3:0] {
      st_idle     = 4'd0,   // Waiting for an opcode word
      st_addr_hi  = 4'd1,
      st_addr_lo  = 4'd2,
      st_data_hi  = 4'd3,
      st_data_lo  = 4'd4,
      st_wb_cycle = 4'd5,   // Strobe held until ack
      st_reply    = 4'd6,   // Single reply word
      st_reply_hi = 4'd7,
      st_reply_lo = 4'd8
   } dbg_state_e;

   // FX2 endpoint FIFO addresses
   localparam logic [1:0] fx2_ep_out = 2'b00;   // Host to device
   localparam logic [1:0] fx2_ep_in  = 2'b10;   // Device to host

   localparam logic [usb_word_w-1:0] err_word = 16'hdead;

endpackage

// File: usb/usb_fx2_fifo_if.sv
// FX2 slave FIFO master, turns endpoint traffic into a receive word stream
// and a transmit word stream
`timescale 1ns/1ps

module usb_fx2_fifo_if (
   input  logic                            clk,
   input  logic                            arst_n_i,

   // FX2 slave FIFO pins
   input  logic                            fx2_flaga_i,     // OUT endpoint empty
   input  logic                            fx2_flagc_i,     // IN endpoint full
   input  logic [pgas_pkg::usb_word_w-1:0] fx2_fd_i,
   output logic [pgas_pkg::usb_word_w-1:0] fx2_fd_o,
   output logic                            fx2_fd_oe_o,
   output logic                            fx2_slrd_o,
   output logic                            fx2_sloe_o,
   output logic                            fx2_slwr_o,
   output logic [1:0]                      fx2_fifoadr_o,

   // Receive stream towards the decoder
   output logic                            rx_valid_o,
   output logic [pgas_pkg::usb_word_w-1:0] rx_data_o,
   input  logic                            rx_ready_i,

   // Transmit stream from the decoder
   input  logic                            tx_valid_i,
   input  logic [pgas_pkg::usb_word_w-1:0] tx_data_i,
   output logic                            tx_ready_o
);

   logic [1:0]                      fifoadr_q;
   logic                            slrd_q;
   logic                            slwr_q;
   logic [pgas_pkg::usb_word_w-1:0] fd_out_q;
   logic                            buf_valid_q;
   logic [pgas_pkg::usb_word_w-1:0] buf_data_q;
   logic                            wr_go;
   logic                            rd_go;
   logic                            rd_need;

   // Write side only when the address already points at the IN endpoint
   assign tx_ready_o = (fifoadr_q == pgas_pkg::fx2_ep_in) && !fx2_flagc_i && !slwr_q;
   assign wr_go      = tx_valid_i && tx_ready_o;

   // One-word buffer, refilled only once it has drained
   assign rd_need = !buf_valid_q && !slrd_q && !fx2_flaga_i;
   assign rd_go   = rd_need && !tx_valid_i && (fifoadr_q == pgas_pkg::fx2_ep_out);

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         fifoadr_q   <= pgas_pkg::fx2_ep_out;
         slrd_q      <= 1'b0;
         slwr_q      <= 1'b0;
         buf_valid_q <= 1'b0;
      end else begin
         slrd_q <= rd_go;   // Strobes last a single cycle
         slwr_q <= wr_go;

         // Switch endpoint only when no strobe is being issued
         if (!rd_go && !wr_go) begin
            if (tx_valid_i && fifoadr_q != pgas_pkg::fx2_ep_in) begin
               fifoadr_q <= pgas_pkg::fx2_ep_in;   // Writes win
            end else if (!tx_valid_i && rd_need && fifoadr_q != pgas_pkg::fx2_ep_out) begin
               fifoadr_q <= pgas_pkg::fx2_ep_out;
            end
         end

         if (slrd_q) begin
            buf_valid_q <= 1'b1;   // Word sampled at end of strobe
         end else if (rx_ready_i) begin
            buf_valid_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (slrd_q) begin
         buf_data_q <= fx2_fd_i;
      end
      if (wr_go) begin
         fd_out_q <= tx_data_i;
      end
   end

   assign fx2_fifoadr_o = fifoadr_q;
   assign fx2_slrd_o    = slrd_q;
   assign fx2_sloe_o    = slrd_q;    // Data bus driven by FX2 while reading
   assign fx2_slwr_o    = slwr_q;
   assign fx2_fd_oe_o   = slwr_q;
   assign fx2_fd_o      = fd_out_q;

   assign rx_valid_o = buf_valid_q;
   assign rx_data_o  = buf_data_q;

endmodule

// File: debug/dbg_cmd_decoder.sv
// Debug command parser with system-control registers, a Wishbone master
// and the reply word sequencer
`timescale 1ns/1ps

module dbg_cmd_decoder #(
   parameter logic [pgas_pkg::usb_word_w-1:0] system_id = 16'hce75
) (
   input  logic                            clk,
   input  logic                            arst_n_i,

   // Command words from the USB block
   input  logic                            rx_valid_i,
   input  logic [pgas_pkg::usb_word_w-1:0] rx_data_i,
   output logic                            rx_ready_o,

   // Reply words to the USB block
   output logic                            tx_valid_o,
   output logic [pgas_pkg::usb_word_w-1:0] tx_data_o,
   input  logic                            tx_ready_i,

   // Wishbone master to global memory
   output logic                            wb_cyc_o,
   output logic                            wb_stb_o,
   output logic                            wb_we_o,
   output logic [pgas_pkg::wb_addr_w-1:0]  wb_adr_o,
   output logic [pgas_pkg::wb_data_w-1:0]  wb_dat_o,
   input  logic                            wb_ack_i,
   input  logic [pgas_pkg::wb_data_w-1:0]  wb_dat_i,

   // System control
   output logic                            cpu_stall_o,
   output logic                            cpu_reset_o,
   output logic                            cpu_start_o
);

   localparam int ww = pgas_pkg::usb_word_w;

   pgas_pkg::dbg_state_e  state_q;
   pgas_pkg::dbg_opcode_e rx_op;
   pgas_pkg::dbg_opcode_e op_q;   // Opcode of the command in progress

   logic                           rx_fire;
   logic                           tx_fire;
   logic                           wb_cyc_q;
   logic                           wb_stb_q;
   logic                           wb_we_q;
   logic                           halt_q;
   logic                           cpu_rst_q;
   logic                           start_q;
   logic [pgas_pkg::wb_addr_w-1:0] adr_q;
   logic [pgas_pkg::wb_data_w-1:0] dat_q;
   logic [ww-1:0]                  reply_q;

   assign rx_op   = pgas_pkg::dbg_opcode_e'(rx_data_i[ww-1:ww-4]);
   assign rx_fire = rx_valid_i && rx_ready_o;
   assign tx_fire = tx_valid_o && tx_ready_i;

   // Words are only taken while collecting a command
   assign rx_ready_o = state_q inside {pgas_pkg::st_idle, pgas_pkg::st_addr_hi,
                                       pgas_pkg::st_addr_lo, pgas_pkg::st_data_hi,
                                       pgas_pkg::st_data_lo};
   assign tx_valid_o = state_q inside {pgas_pkg::st_reply, pgas_pkg::st_reply_hi,
                                       pgas_pkg::st_reply_lo};

   always_comb begin
      case (state_q)
         pgas_pkg::st_reply_hi: tx_data_o = dat_q[pgas_pkg::wb_data_w-1:ww];
         pgas_pkg::st_reply_lo: tx_data_o = dat_q[ww-1:0];
         default:               tx_data_o = reply_q;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q   <= pgas_pkg::st_idle;
         wb_cyc_q  <= 1'b0;
         wb_stb_q  <= 1'b0;
         wb_we_q   <= 1'b0;
         halt_q    <= 1'b0;
         cpu_rst_q <= 1'b0;
         start_q   <= 1'b0;
      end else begin
         start_q <= 1'b0;
         case (state_q)
            pgas_pkg::st_idle: begin
               if (rx_fire) begin
                  case (rx_op)
                     pgas_pkg::op_sys_ctrl: begin
                        halt_q    <= rx_data_i[pgas_pkg::ctrl_halt_bit];
                        cpu_rst_q <= rx_data_i[pgas_pkg::ctrl_reset_bit];
                        start_q   <= rx_data_i[pgas_pkg::ctrl_start_bit];
                        state_q   <= pgas_pkg::st_reply;
                     end
                     pgas_pkg::op_mem_write,
                     pgas_pkg::op_mem_read: state_q <= pgas_pkg::st_addr_hi;
                     default:               state_q <= pgas_pkg::st_reply;   // ID or error
                  endcase
               end
            end
            pgas_pkg::st_addr_hi: begin
               if (rx_fire) begin
                  state_q <= pgas_pkg::st_addr_lo;
               end
            end
            pgas_pkg::st_addr_lo: begin
               if (rx_fire) begin
                  if (op_q == pgas_pkg::op_mem_write) begin
                     state_q <= pgas_pkg::st_data_hi;
                  end else begin
                     state_q  <= pgas_pkg::st_wb_cycle;   // Read starts right away
                     wb_cyc_q <= 1'b1;
                     wb_stb_q <= 1'b1;
                     wb_we_q  <= 1'b0;
                  end
               end
            end
            pgas_pkg::st_data_hi: begin
               if (rx_fire) begin
                  state_q <= pgas_pkg::st_data_lo;
               end
            end
            pgas_pkg::st_data_lo: begin
               if (rx_fire) begin
                  state_q  <= pgas_pkg::st_wb_cycle;
                  wb_cyc_q <= 1'b1;
                  wb_stb_q <= 1'b1;
                  wb_we_q  <= 1'b1;
               end
            end
            pgas_pkg::st_wb_cycle: begin
               if (wb_ack_i) begin
                  wb_cyc_q <= 1'b0;
                  wb_stb_q <= 1'b0;
                  wb_we_q  <= 1'b0;
                  state_q  <= (op_q == pgas_pkg::op_mem_write) ? pgas_pkg::st_reply
                                                               : pgas_pkg::st_reply_hi;
               end
            end
            pgas_pkg::st_reply: begin
               if (tx_fire) begin
                  state_q <= pgas_pkg::st_idle;
               end
            end
            pgas_pkg::st_reply_hi: begin
               if (tx_fire) begin
                  state_q <= pgas_pkg::st_reply_lo;
               end
            end
            pgas_pkg::st_reply_lo: begin
               if (tx_fire) begin
                  state_q <= pgas_pkg::st_idle;
               end
            end
            default: state_q <= pgas_pkg::st_idle;
         endcase
      end
   end

   // Command payload, address and data halves
   always_ff @(posedge clk) begin
      if (rx_fire) begin
         case (state_q)
            pgas_pkg::st_idle: begin
               op_q <= rx_op;
               case (rx_op)
                  pgas_pkg::op_read_id:   reply_q <= system_id;
                  pgas_pkg::op_sys_ctrl,
                  pgas_pkg::op_mem_write: reply_q <= rx_data_i;   // Echo
                  default:                reply_q <= pgas_pkg::err_word;
               endcase
            end
            pgas_pkg::st_addr_hi: adr_q[pgas_pkg::wb_addr_w-1:ww] <= rx_data_i;
            pgas_pkg::st_addr_lo: adr_q[ww-1:0] <= rx_data_i;
            pgas_pkg::st_data_hi: dat_q[pgas_pkg::wb_data_w-1:ww] <= rx_data_i;
            pgas_pkg::st_data_lo: dat_q[ww-1:0] <= rx_data_i;
            default: ;
         endcase
      end
      if (state_q == pgas_pkg::st_wb_cycle && wb_ack_i && !wb_we_q) begin
         dat_q <= wb_dat_i;   // Read data for the two reply words
      end
   end

   assign wb_cyc_o = wb_cyc_q;
   assign wb_stb_o = wb_stb_q;
   assign wb_we_o  = wb_we_q;
   assign wb_adr_o = adr_q;
   assign wb_dat_o = dat_q;

   assign cpu_stall_o = halt_q;
   assign cpu_reset_o = cpu_rst_q;
   assign cpu_start_o = start_q;

endmodule

// File: source/wb_sram_sp.sv
// Single-port Wishbone SRAM, decodes only the low word address bits
`timescale 1ns/1ps

module wb_sram_sp #(
   parameter int mem_words = 1024
) (
   input  logic                           clk,
   input  logic                           arst_n_i,
   input  logic                           wb_cyc_i,
   input  logic                           wb_stb_i,
   input  logic                           wb_we_i,
   input  logic [pgas_pkg::wb_addr_w-1:0] wb_adr_i,
   input  logic [pgas_pkg::wb_data_w-1:0] wb_dat_i,
   output logic                           wb_ack_o,
   output logic [pgas_pkg::wb_data_w-1:0] wb_dat_o
);

   localparam int aw = $clog2(mem_words);

   logic [pgas_pkg::wb_data_w-1:0] mem [mem_words];
   logic [aw-1:0]                  word_idx;
   logic                           ack_q;
   logic                           access;

   // Upper PGAS bits fall away here, so addresses alias
   assign word_idx = wb_adr_i[aw+1:2];

   // A held strobe is served once
   assign access = wb_cyc_i && wb_stb_i && !ack_q;

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= access;   // One cycle from strobe to ack
      end
   end

   always_ff @(posedge clk) begin
      if (access) begin
         if (wb_we_i) begin
            mem[word_idx] <= wb_dat_i;
         end
         wb_dat_o <= mem[word_idx];   // Valid with the ack
      end
   end

   assign wb_ack_o = ack_q;

endmodule

// File: source/system_pgas_top.sv
// PGAS debug demo top level with the USB FIFO interface, the command
// decoder and the global memory
`timescale 1ns/1ps

module system_pgas_top #(
   parameter int                              mem_words = 1024,
   parameter logic [pgas_pkg::usb_word_w-1:0] system_id = 16'hce75
) (
   input  logic                            clk,
   input  logic                            arst_n_i,

   // FX2 slave FIFO
   input  logic                            fx2_flaga_i,
   input  logic                            fx2_flagc_i,
   input  logic [pgas_pkg::usb_word_w-1:0] fx2_fd_i,
   output logic [pgas_pkg::usb_word_w-1:0] fx2_fd_o,
   output logic                            fx2_fd_oe_o,
   output logic                            fx2_slrd_o,
   output logic                            fx2_sloe_o,
   output logic                            fx2_slwr_o,
   output logic [1:0]                      fx2_fifoadr_o,

   // System control
   output logic                            cpu_stall_o,
   output logic                            cpu_reset_o,
   output logic                            cpu_start_o
);

   logic                            rx_valid;
   logic [pgas_pkg::usb_word_w-1:0] rx_data;
   logic                            rx_ready;
   logic                            tx_valid;
   logic [pgas_pkg::usb_word_w-1:0] tx_data;
   logic                            tx_ready;

   logic                            wb_cyc;
   logic                            wb_stb;
   logic                            wb_we;
   logic [pgas_pkg::wb_addr_w-1:0]  wb_adr;
   logic [pgas_pkg::wb_data_w-1:0]  wb_dat_w;
   logic                            wb_ack;
   logic [pgas_pkg::wb_data_w-1:0]  wb_dat_r;

   usb_fx2_fifo_if u_usb (
      .clk           (clk),
      .arst_n_i      (arst_n_i),
      .fx2_flaga_i   (fx2_flaga_i),
      .fx2_flagc_i   (fx2_flagc_i),
      .fx2_fd_i      (fx2_fd_i),
      .fx2_fd_o      (fx2_fd_o),
      .fx2_fd_oe_o   (fx2_fd_oe_o),
      .fx2_slrd_o    (fx2_slrd_o),
      .fx2_sloe_o    (fx2_sloe_o),
      .fx2_slwr_o    (fx2_slwr_o),
      .fx2_fifoadr_o (fx2_fifoadr_o),
      .rx_valid_o    (rx_valid),
      .rx_data_o     (rx_data),
      .rx_ready_i    (rx_ready),
      .tx_valid_i    (tx_valid),
      .tx_data_i     (tx_data),
      .tx_ready_o    (tx_ready)
   );

   dbg_cmd_decoder #(
      .system_id (system_id)
   ) u_dbg (
      .clk         (clk),
      .arst_n_i    (arst_n_i),
      .rx_valid_i  (rx_valid),
      .rx_data_i   (rx_data),
      .rx_ready_o  (rx_ready),
      .tx_valid_o  (tx_valid),
      .tx_data_o   (tx_data),
      .tx_ready_i  (tx_ready),
      .wb_cyc_o    (wb_cyc),
      .wb_stb_o    (wb_stb),
      .wb_we_o     (wb_we),
      .wb_adr_o    (wb_adr),
      .wb_dat_o    (wb_dat_w),
      .wb_ack_i    (wb_ack),
      .wb_dat_i    (wb_dat_r),
      .cpu_stall_o (cpu_stall_o),
      .cpu_reset_o (cpu_reset_o),
      .cpu_start_o (cpu_start_o)
   );

   // Global memory, full PGAS address goes in
   wb_sram_sp #(
      .mem_words (mem_words)
   ) u_gram (
      .clk      (clk),
      .arst_n_i (arst_n_i),
      .wb_cyc_i (wb_cyc),
      .wb_stb_i (wb_stb),
      .wb_we_i  (wb_we),
      .wb_adr_i (wb_adr),
      .wb_dat_i (wb_dat_w),
      .wb_ack_o (wb_ack),
      .wb_dat_o (wb_dat_r)
   );

endmodule

// File: tb/tb_cmd_table.svh
// Command table for the PGAS system testbench, with stimulus words,
// expected reply words and expected system-control levels per row

localparam int max_rows = 16;

string       row_name   [max_rows];
int          row_ncmd   [max_rows];
logic [15:0] row_cmd    [max_rows][5];
int          row_nrep   [max_rows];
logic [15:0] row_rep    [max_rows][2];
logic        row_stall  [max_rows];
logic        row_rst    [max_rows];
int          row_starts [max_rows];   // Start pulses expected within the row
int          row_cnt = 0;

task automatic add_row(input string name, input int nc,
                       input logic [15:0] c0, input logic [15:0] c1, input logic [15:0] c2,
                       input logic [15:0] c3, input logic [15:0] c4,
                       input int nr, input logic [15:0] r0, input logic [15:0] r1,
                       input logic stall, input logic rst, input int starts);
   row_name[row_cnt]   = name;
   row_ncmd[row_cnt]   = nc;
   row_cmd[row_cnt][0] = c0;
   row_cmd[row_cnt][1] = c1;
   row_cmd[row_cnt][2] = c2;
   row_cmd[row_cnt][3] = c3;
   row_cmd[row_cnt][4] = c4;
   row_nrep[row_cnt]   = nr;
   row_rep[row_cnt][0] = r0;
   row_rep[row_cnt][1] = r1;
   row_stall[row_cnt]  = stall;
   row_rst[row_cnt]    = rst;
   row_starts[row_cnt] = starts;
   row_cnt++;
endtask

task automatic load_table();
   // name, word count, cmd 0..4, reply count, reply 0..1, stall, cpu reset, start pulses
   add_row("read_id", 1, 16'h1000, 16'h0, 16'h0, 16'h0, 16'h0, 1, 16'hce75, 16'h0, 1'b0, 1'b0, 0);
   add_row("mem_write", 5, 16'h3000, 16'h0000, 16'h0010, 16'h1234, 16'h5678,
           1, 16'h3000, 16'h0, 1'b0, 1'b0, 0);
   add_row("mem_read", 3, 16'h4000, 16'h0000, 16'h0010, 16'h0, 16'h0,
           2, 16'h1234, 16'h5678, 1'b0, 1'b0, 0);
   add_row("alias_4k", 3, 16'h4000, 16'h0000, 16'h1010, 16'h0, 16'h0,
           2, 16'h1234, 16'h5678, 1'b0, 1'b0, 0);
   add_row("alias_bit31", 3, 16'h4000, 16'h8000, 16'h0010, 16'h0, 16'h0,
           2, 16'h1234, 16'h5678, 1'b0, 1'b0, 0);
   add_row("write_high", 5, 16'h3abc, 16'h7fff, 16'h0204, 16'hcafe, 16'hf00d,
           1, 16'h3abc, 16'h0, 1'b0, 1'b0, 0);
   add_row("read_low", 3, 16'h4000, 16'h0000, 16'h0204, 16'h0, 16'h0,
           2, 16'hcafe, 16'hf00d, 1'b0, 1'b0, 0);
   add_row("ctrl_halt_rst", 1, 16'h2003, 16'h0, 16'h0, 16'h0, 16'h0,
           1, 16'h2003, 16'h0, 1'b1, 1'b1, 0);
   add_row("ctrl_start", 1, 16'h2004, 16'h0, 16'h0, 16'h0, 16'h0,
           1, 16'h2004, 16'h0, 1'b0, 1'b0, 1);
   add_row("ctrl_halt_start", 1, 16'h2005, 16'h0, 16'h0, 16'h0, 16'h0,
           1, 16'h2005, 16'h0, 1'b1, 1'b0, 1);
   add_row("bad_op_7", 1, 16'h7123, 16'h0, 16'h0, 16'h0, 16'h0, 1, 16'hdead, 16'h0, 1'b1, 1'b0, 0);
   add_row("bad_op_0", 1, 16'h0000, 16'h0, 16'h0, 16'h0, 16'h0, 1, 16'hdead, 16'h0, 1'b1, 1'b0, 0);
   add_row("id_after_err", 1, 16'h1fff, 16'h0, 16'h0, 16'h0, 16'h0,
           1, 16'hce75, 16'h0, 1'b1, 1'b0, 0);
   add_row("ctrl_rst_only", 1, 16'h2002, 16'h0, 16'h0, 16'h0, 16'h0,
           1, 16'h2002, 16'h0, 1'b0, 1'b1, 0);
   add_row("ctrl_clear", 1, 16'h2000, 16'h0, 16'h0, 16'h0, 16'h0,
           1, 16'h2000, 16'h0, 1'b0, 1'b0, 0);
   add_row("mem_read_again", 3, 16'h4000, 16'h0000, 16'h0010, 16'h0, 16'h0,
           2, 16'h1234, 16'h5678, 1'b0, 1'b0, 0);
endtask

// File: tb/tb_system_pgas.sv
// Testbench for the PGAS debug system with FX2 FIFO models, clock, reset,
// table-driven command loop, checks and watchdog
`timescale 1ns/1ps

module tb_system_pgas;

   localparam int row_cycles = 200;   // Watchdog budget per table row

   logic        clk          = 1'b0;
   logic        arst_n_i     = 1'b0;
   logic        fx2_flaga_i  = 1'b1;   // OUT endpoint starts empty
   logic        fx2_flagc_i  = 1'b0;
   logic [15:0] fx2_fd_i     = 16'h0000;
   logic [15:0] fx2_fd_o;
   logic        fx2_fd_oe_o;
   logic        fx2_slrd_o;
   logic        fx2_sloe_o;
   logic        fx2_slwr_o;
   logic [1:0]  fx2_fifoadr_o;
   logic        cpu_stall_o;
   logic        cpu_reset_o;
   logic        cpu_start_o;

   logic [15:0] out_q [$];   // Host words waiting in the OUT endpoint
   logic [15:0] in_q  [$];   // Words the DUT wrote to the IN endpoint
   logic [1:0]  adr_prev     = pgas_pkg::fx2_ep_out;   // FIFO address one cycle back
   logic        pop_pending  = 1'b0;
   logic        bp_en        = 1'b0;
   logic        table_loaded = 1'b0;
   logic [31:0] rnd;
   integer      seed;
   int          err_cnt      = 0;
   int          start_cnt    = 0;
   int          words_pushed = 0;
   int          words_read   = 0;
   int          n_pass       = 0;
   int          n_fail       = 0;

   `include "tb_cmd_table.svh"

   always #10 clk = ~clk;

   system_pgas_top DUT (
      .clk           (clk),
      .arst_n_i      (arst_n_i),
      .fx2_flaga_i   (fx2_flaga_i),
      .fx2_flagc_i   (fx2_flagc_i),
      .fx2_fd_i      (fx2_fd_i),
      .fx2_fd_o      (fx2_fd_o),
      .fx2_fd_oe_o   (fx2_fd_oe_o),
      .fx2_slrd_o    (fx2_slrd_o),
      .fx2_sloe_o    (fx2_sloe_o),
      .fx2_slwr_o    (fx2_slwr_o),
      .fx2_fifoadr_o (fx2_fifoadr_o),
      .cpu_stall_o   (cpu_stall_o),
      .cpu_reset_o   (cpu_reset_o),
      .cpu_start_o   (cpu_start_o)
   );

   // OUT endpoint model that pops a word after the strobe edge
   always @(negedge clk) begin
      if (pop_pending) begin
         void'(out_q.pop_front());
         words_read++;
      end
      pop_pending = fx2_slrd_o && (fx2_fifoadr_o == pgas_pkg::fx2_ep_out);
      if (fx2_slrd_o && (fx2_fifoadr_o != pgas_pkg::fx2_ep_out ||
                         adr_prev != pgas_pkg::fx2_ep_out || !fx2_sloe_o)) begin
         $display("error: read strobe without a settled OUT address or output enable");
         err_cnt++;
      end
      adr_prev    <= fx2_fifoadr_o;
      fx2_flaga_i <= (out_q.size() == 0);
      fx2_fd_i    <= (out_q.size() > 0) ? out_q[0] : 16'h0000;
   end

   // IN endpoint model with random full flag
   always @(negedge clk) begin
      rnd = $random(seed);
      fx2_flagc_i <= bp_en && rnd[0];
      if (fx2_slwr_o) begin
         if (fx2_fifoadr_o != pgas_pkg::fx2_ep_in || adr_prev != pgas_pkg::fx2_ep_in) begin
            $display("error: write strobe while the FIFO address went from %b to %b",
                     adr_prev, fx2_fifoadr_o);
            err_cnt++;
         end else begin
            if (fx2_flagc_i) begin
               $display("error: write strobe issued while the IN FIFO was full");
               err_cnt++;
            end
            in_q.push_back(fx2_fd_o);
         end
      end
      if (fx2_fd_oe_o !== fx2_slwr_o) begin
         $display("error: data output enable does not follow the write strobe");
         err_cnt++;
      end
   end

   always @(negedge clk) begin
      if (cpu_start_o) begin
         start_cnt++;   // One count per cycle high
      end
   end

   task automatic report_test(input string name, input logic ok);
      if (ok) begin
         n_pass++;
         $display("test %s: pass", name);
      end else begin
         n_fail++;
         $display("test %s: fail", name);
      end
   endtask

   task automatic check_reset_state();
      int errs;
      errs = err_cnt;
      if ({fx2_slrd_o, fx2_sloe_o, fx2_slwr_o, fx2_fd_oe_o} !== 4'b0000) begin
         $display("mismatch reset_state strobes expected 0000 actual %b",
                  {fx2_slrd_o, fx2_sloe_o, fx2_slwr_o, fx2_fd_oe_o});
         err_cnt++;
      end
      if ({cpu_stall_o, cpu_reset_o, cpu_start_o, DUT.wb_cyc, DUT.wb_stb} !== 5'b00000) begin
         $display("mismatch reset_state control expected 00000 actual %b",
                  {cpu_stall_o, cpu_reset_o, cpu_start_o, DUT.wb_cyc, DUT.wb_stb});
         err_cnt++;
      end
      if (fx2_fifoadr_o !== pgas_pkg::fx2_ep_out) begin
         $display("mismatch reset_state fifoadr expected %b actual %b",
                  pgas_pkg::fx2_ep_out, fx2_fifoadr_o);
         err_cnt++;
      end
      report_test("reset_state", err_cnt == errs);
   endtask

   task automatic run_row(input int r);
      int errs;
      int starts_base;
      int k;
      @(posedge clk);
      errs        = err_cnt;
      starts_base = start_cnt;
      for (k = 0; k < row_ncmd[r]; k++) begin
         out_q.push_back(row_cmd[r][k]);
      end
      words_pushed += row_ncmd[r];
      while (in_q.size() < row_nrep[r]) begin
         @(posedge clk);
      end
      for (k = 0; k < row_nrep[r]; k++) begin
         if (in_q[k] !== row_rep[r][k]) begin
            $display("mismatch %s reply %0d expected %h actual %h",
                     row_name[r], k, row_rep[r][k], in_q[k]);
            err_cnt++;
         end
      end
      in_q.delete();
      if (start_cnt - starts_base != row_starts[r]) begin
         $display("mismatch %s start pulses expected %0d actual %0d",
                  row_name[r], row_starts[r], start_cnt - starts_base);
         err_cnt++;
      end
      if (out_q.size() != 0) begin
         $display("error: %s left %0d words unread in the OUT FIFO", row_name[r], out_q.size());
         err_cnt++;
      end
      @(negedge clk);
      if (cpu_stall_o !== row_stall[r]) begin
         $display("mismatch %s cpu_stall_o expected %b actual %b",
                  row_name[r], row_stall[r], cpu_stall_o);
         err_cnt++;
      end
      if (cpu_reset_o !== row_rst[r]) begin
         $display("mismatch %s cpu_reset_o expected %b actual %b",
                  row_name[r], row_rst[r], cpu_reset_o);
         err_cnt++;
      end
      report_test(row_name[r], err_cnt == errs);
   endtask

   initial begin
      int errs;
      seed = 32'ha925c6f3;
      load_table();
      table_loaded = 1'b1;
      repeat (8) @(posedge clk);
      @(negedge clk);
      arst_n_i <= 1'b1;
      @(negedge clk);
      check_reset_state();
      @(posedge clk);
      bp_en = 1'b1;   // IN-full back-pressure for every row
      for (int i = 0; i < row_cnt; i++) begin
         run_row(i);
      end
      repeat (20) @(posedge clk);
      errs = err_cnt;
      if (in_q.size() != 0) begin
         $display("error: %0d reply words arrived that no command asked for", in_q.size());
         err_cnt++;
      end
      if (words_read != words_pushed) begin
         $display("mismatch drain OUT words expected %0d actual %0d", words_pushed, words_read);
         err_cnt++;
      end
      report_test("drain", err_cnt == errs);
      $display("tests passed %0d failed %0d, errors %0d", n_pass, n_fail, err_cnt);
      if (n_fail == 0 && err_cnt == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

   // Watchdog sized from the table length plus reset and drain
   initial begin
      wait (table_loaded);
      repeat ((row_cnt + 1) * row_cycles) @(posedge clk);
      $display("error: run did not finish within %0d cycles", (row_cnt + 1) * row_cycles);
      $display("*** FAILED ***");
      $finish;
   end

endmodule

// File: build.f
+incdir+tb
common/pgas_pkg.sv
usb/usb_fx2_fifo_if.sv
debug/dbg_cmd_decoder.sv
source/wb_sram_sp.sv
source/system_pgas_top.sv
tb/tb_system_pgas.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the PGAS system testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps -f build.f \
   --top-module tb_system_pgas -Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "Verilator compile failed"
   exit 1
fi

./obj_dir/Vtb_system_pgas > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q '\*\*\* FAILED \*\*\*' "$LOG"; then
   exit 1
fi
exit 0
